/* exec_defines.svh */
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// data path width.
`define EXEC_DATA_W 32

// register file address width.
`define EXEC_REG_W 5

// shift amount field width.
`define EXEC_SA_W 5

// immediate field width.
`define EXEC_IMM_W 16

`endif

/* isa_pkg.sv */
package isa_pkg;

    // width of one instruction word.
    localparam int INSTR_W = 32;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,  // signed add, traps on overflow.
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,  // signed subtract, traps on overflow.
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_SLLV = 4'd11, // variable forms take the amount from a.
        ALU_SRLV = 4'd12,
        ALU_SRAV = 4'd13,
        ALU_LUI  = 4'd14
    } alu_funct_e;

    // instruction field positions.
    localparam int RS_MSB  = 25;
    localparam int RS_LSB  = 21;
    localparam int RT_MSB  = 20;
    localparam int RT_LSB  = 16;
    localparam int RD_MSB  = 15;
    localparam int RD_LSB  = 11;
    localparam int SA_MSB  = 10;
    localparam int SA_LSB  = 6;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;

endpackage

/* exec_ctrl_pkg.sv */
package exec_ctrl_pkg;

    // first ALU operand.
    typedef enum logic {
        SRC_A_RS   = 1'b0,
        SRC_A_ZERO = 1'b1
    } alu_src_a_e;

    // second ALU operand.
    typedef enum logic [1:0] {
        SRC_B_RT       = 2'd0,
        SRC_B_IMM_SIGN = 2'd1,
        SRC_B_IMM_ZERO = 2'd2
    } alu_src_b_e;

    // writeback data source.
    typedef enum logic [2:0] {
        REG_SRC_ALU    = 3'd0,
        REG_SRC_PCADD4 = 3'd1, // link address for jal and bgezal.
        REG_SRC_RS     = 3'd2,
        REG_SRC_HI     = 3'd3,
        REG_SRC_LO     = 3'd4,
        REG_SRC_CP0    = 3'd5,
        REG_SRC_FLAG   = 3'd6, // slt family.
        REG_SRC_LLBIT  = 3'd7  // sc result.
    } reg_src_e;

    typedef enum logic [1:0] {
        FLAG_EQ  = 2'd0,
        FLAG_NE  = 2'd1,
        FLAG_LT  = 2'd2,
        FLAG_LTU = 2'd3
    } flag_sel_e;

    typedef enum logic [1:0] {
        DEST_RD = 2'd0,
        DEST_RT = 2'd1,
        DEST_RA = 2'd2  // register 31.
    } dest_sel_e;

endpackage

/* exec_stage_reg.sv */
`timescale 1ns/10ps
`include "exec_defines.svh"

module exec_stage_reg (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stall,
    input  logic                         nullify,
    input  logic                         valid_in,
    input  logic [isa_pkg::INSTR_W-1:0]  instr_in,
    input  isa_pkg::alu_funct_e          alu_funct_in,
    input  exec_ctrl_pkg::alu_src_a_e    alu_src_a_in,
    input  exec_ctrl_pkg::alu_src_b_e    alu_src_b_in,
    input  exec_ctrl_pkg::reg_src_e      reg_src_in,
    input  exec_ctrl_pkg::flag_sel_e     flag_sel_in,
    input  exec_ctrl_pkg::dest_sel_e     dest_sel_in,
    input  logic [`EXEC_DATA_W-1:0]      pcadd4_in,
    input  logic [`EXEC_DATA_W-1:0]      rs_in,
    input  logic [`EXEC_DATA_W-1:0]      rt_in,
    input  logic [`EXEC_DATA_W-1:0]      cp0_in,
    output logic                         valid_q,
    output logic [isa_pkg::INSTR_W-1:0]  instr_q,
    output isa_pkg::alu_funct_e          alu_funct_q,
    output exec_ctrl_pkg::alu_src_a_e    alu_src_a_q,
    output exec_ctrl_pkg::alu_src_b_e    alu_src_b_q,
    output exec_ctrl_pkg::reg_src_e      reg_src_q,
    output exec_ctrl_pkg::flag_sel_e     flag_sel_q,
    output exec_ctrl_pkg::dest_sel_e     dest_sel_q,
    output logic [`EXEC_DATA_W-1:0]      pcadd4_q,
    output logic [`EXEC_DATA_W-1:0]      rs_q,
    output logic [`EXEC_DATA_W-1:0]      rt_q,
    output logic [`EXEC_DATA_W-1:0]      cp0_q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q     <= 1'b0;
            instr_q     <= '0;
            alu_funct_q <= isa_pkg::ALU_ADD;
            alu_src_a_q <= exec_ctrl_pkg::SRC_A_RS;
            alu_src_b_q <= exec_ctrl_pkg::SRC_B_RT;
            reg_src_q   <= exec_ctrl_pkg::REG_SRC_ALU;
            flag_sel_q  <= exec_ctrl_pkg::FLAG_EQ;
            dest_sel_q  <= exec_ctrl_pkg::DEST_RD;
            pcadd4_q    <= '0;
            rs_q        <= '0;
            rt_q        <= '0;
            cp0_q       <= '0;
        end else if (nullify) begin
            valid_q     <= 1'b0;  // bubble, fields keep their old values.
        end else if (!stall) begin
            valid_q     <= valid_in;
            instr_q     <= instr_in;
            alu_funct_q <= alu_funct_in;
            alu_src_a_q <= alu_src_a_in;
            alu_src_b_q <= alu_src_b_in;
            reg_src_q   <= reg_src_in;
            flag_sel_q  <= flag_sel_in;
            dest_sel_q  <= dest_sel_in;
            pcadd4_q    <= pcadd4_in;
            rs_q        <= rs_in;
            rt_q        <= rt_in;
            cp0_q       <= cp0_in;
        end
    end

    // out of reset the stage stays empty until a load happens.
    a_valid_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rst_n) && !(valid_in && !stall && !nullify) |=> !valid_q);

    a_ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({stall, nullify}));

endmodule

/* exec_operand_select.sv */
`timescale 1ns/10ps
`include "exec_defines.svh"

module exec_operand_select (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         valid,
    input  logic [isa_pkg::INSTR_W-1:0]  instr,
    input  exec_ctrl_pkg::alu_src_a_e    alu_src_a,
    input  exec_ctrl_pkg::alu_src_b_e    alu_src_b,
    input  logic [`EXEC_DATA_W-1:0]      rs_q,
    input  logic [`EXEC_DATA_W-1:0]      rt_q,
    input  logic                         forward_rs,
    input  logic                         forward_rt,
    input  logic [`EXEC_DATA_W-1:0]      fwd_rs_data,
    input  logic [`EXEC_DATA_W-1:0]      fwd_rt_data,
    output logic [`EXEC_DATA_W-1:0]      alu_a,
    output logic [`EXEC_DATA_W-1:0]      alu_b,
    output logic [`EXEC_SA_W-1:0]        alu_sa,
    output logic [`EXEC_DATA_W-1:0]      rs_data,
    output logic [`EXEC_DATA_W-1:0]      rt_data,
    output logic [`EXEC_REG_W-1:0]       rd,
    output logic [`EXEC_REG_W-1:0]       rt_addr
);

    logic [`EXEC_IMM_W-1:0]  immed;
    logic [`EXEC_DATA_W-1:0] imm_sign;
    logic [`EXEC_DATA_W-1:0] imm_zero;

    assign immed   = instr[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB];
    assign rd      = instr[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
    assign rt_addr = instr[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
    assign alu_sa  = instr[isa_pkg::SA_MSB:isa_pkg::SA_LSB];

    // late forwarding from mem and wb.
    assign rs_data = forward_rs ? fwd_rs_data : rs_q;
    assign rt_data = forward_rt ? fwd_rt_data : rt_q;

    assign imm_sign = {{(`EXEC_DATA_W-`EXEC_IMM_W){immed[`EXEC_IMM_W-1]}}, immed};
    assign imm_zero = {{(`EXEC_DATA_W-`EXEC_IMM_W){1'b0}}, immed};

    assign alu_a = (alu_src_a == exec_ctrl_pkg::SRC_A_ZERO) ? '0 : rs_data;

    always_comb begin
        case (alu_src_b)
            exec_ctrl_pkg::SRC_B_IMM_SIGN: alu_b = imm_sign;
            exec_ctrl_pkg::SRC_B_IMM_ZERO: alu_b = imm_zero;
            default:                       alu_b = rt_data;
        endcase
    end

    // the hazard unit must settle the forward bits for a live instruction.
    a_fwd_known: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> !$isunknown({forward_rs, forward_rt}));

endmodule

/* alu.sv */
`timescale 1ns/10ps
`include "exec_defines.svh"

module alu #(
    parameter int W    = `EXEC_DATA_W,
    parameter int SA_W = `EXEC_SA_W
) (
    input  logic [W-1:0]        a,
    input  logic [W-1:0]        b,
    input  logic [SA_W-1:0]     sa,
    input  isa_pkg::alu_funct_e funct,
    output logic [W-1:0]        y,
    output logic                eq,
    output logic                lt,
    output logic                ltu,
    output logic                overflow
);

    logic [W-1:0]    sum;
    logic [W-1:0]    diff;
    logic [SA_W-1:0] var_sa;
    logic            add_ovf;
    logic            sub_ovf;

    assign sum    = a + b;
    assign diff   = a - b;
    assign var_sa = a[SA_W-1:0];

    // same-sign operands giving a result of the other sign.
    assign add_ovf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
    assign sub_ovf = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);

    always_comb begin
        case (funct)
            isa_pkg::ALU_ADD,
            isa_pkg::ALU_ADDU: y = sum;
            isa_pkg::ALU_SUB,
            isa_pkg::ALU_SUBU: y = diff;
            isa_pkg::ALU_AND:  y = a & b;
            isa_pkg::ALU_OR:   y = a | b;
            isa_pkg::ALU_XOR:  y = a ^ b;
            isa_pkg::ALU_NOR:  y = ~(a | b);
            isa_pkg::ALU_SLL:  y = b << sa;
            isa_pkg::ALU_SRL:  y = b >> sa;
            isa_pkg::ALU_SRA:  y = $signed(b) >>> sa;
            isa_pkg::ALU_SLLV: y = b << var_sa;
            isa_pkg::ALU_SRLV: y = b >> var_sa;
            isa_pkg::ALU_SRAV: y = $signed(b) >>> var_sa;
            isa_pkg::ALU_LUI:  y = {b[W/2-1:0], {(W/2){1'b0}}};
            default:           y = '0;
        endcase
    end

    always_comb begin
        case (funct)
            isa_pkg::ALU_ADD: overflow = add_ovf;
            isa_pkg::ALU_SUB: overflow = sub_ovf;
            default:          overflow = 1'b0; // unsigned forms never trap.
        endcase
    end

    // compares run for every funct, branches use them alongside the add.
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    // decode only issues the fifteen defined codes.
    always_comb begin
        a_funct_legal: assert ($isunknown(funct) || funct <= isa_pkg::ALU_LUI);
    end

endmodule

/* exec_result_select.sv */
`timescale 1ns/10ps
`include "exec_defines.svh"

module exec_result_select (
    input  exec_ctrl_pkg::flag_sel_e  flag_sel,
    input  exec_ctrl_pkg::reg_src_e   reg_src,
    input  exec_ctrl_pkg::dest_sel_e  dest_sel,
    input  logic [`EXEC_DATA_W-1:0]   alu_y,
    input  logic                      eq,
    input  logic                      lt,
    input  logic                      ltu,
    input  logic [`EXEC_DATA_W-1:0]   pcadd4,
    input  logic [`EXEC_DATA_W-1:0]   rs_data,
    input  logic [`EXEC_DATA_W-1:0]   hi,
    input  logic [`EXEC_DATA_W-1:0]   lo,
    input  logic [`EXEC_DATA_W-1:0]   cp0,
    input  logic                      llbit,
    input  logic [`EXEC_REG_W-1:0]    rd,
    input  logic [`EXEC_REG_W-1:0]    rt_addr,
    output logic                      flag,
    output logic [`EXEC_DATA_W-1:0]   dest_reg_data,
    output logic [`EXEC_REG_W-1:0]    dest_reg
);

    always_comb begin
        case (flag_sel)
            exec_ctrl_pkg::FLAG_NE:  flag = !eq;
            exec_ctrl_pkg::FLAG_LT:  flag = lt;
            exec_ctrl_pkg::FLAG_LTU: flag = ltu;
            default:                 flag = eq;
        endcase
    end

    always_comb begin
        case (reg_src)
            exec_ctrl_pkg::REG_SRC_PCADD4: dest_reg_data = pcadd4;
            exec_ctrl_pkg::REG_SRC_RS:     dest_reg_data = rs_data;
            exec_ctrl_pkg::REG_SRC_HI:     dest_reg_data = hi;
            exec_ctrl_pkg::REG_SRC_LO:     dest_reg_data = lo;
            exec_ctrl_pkg::REG_SRC_CP0:    dest_reg_data = cp0;
            exec_ctrl_pkg::REG_SRC_FLAG: begin
                dest_reg_data = {{(`EXEC_DATA_W-1){1'b0}}, flag};
            end
            exec_ctrl_pkg::REG_SRC_LLBIT: begin
                dest_reg_data = {{(`EXEC_DATA_W-1){1'b0}}, llbit};
            end
            default:                       dest_reg_data = alu_y;
        endcase
    end

    always_comb begin
        case (dest_sel)
            exec_ctrl_pkg::DEST_RT: dest_reg = rt_addr;
            exec_ctrl_pkg::DEST_RA: dest_reg = {`EXEC_REG_W{1'b1}}; // link register.
            default:                dest_reg = rd;
        endcase
    end

endmodule

/* stage_execute.sv */
`timescale 1ns/10ps
`include "exec_defines.svh"

module stage_execute (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         valid_in,
    input  logic [isa_pkg::INSTR_W-1:0]  instr_in,
    input  isa_pkg::alu_funct_e          alu_funct_in,
    input  exec_ctrl_pkg::alu_src_a_e    alu_src_a_in,
    input  exec_ctrl_pkg::alu_src_b_e    alu_src_b_in,
    input  exec_ctrl_pkg::reg_src_e      reg_src_in,
    input  exec_ctrl_pkg::flag_sel_e     flag_sel_in,
    input  exec_ctrl_pkg::dest_sel_e     dest_sel_in,
    input  logic [`EXEC_DATA_W-1:0]      pcadd4_in,
    input  logic [`EXEC_DATA_W-1:0]      rs_in,
    input  logic [`EXEC_DATA_W-1:0]      rt_in,
    input  logic [`EXEC_DATA_W-1:0]      cp0_in,
    input  logic                         stall,
    input  logic                         nullify,
    input  logic                         forward_rs,
    input  logic                         forward_rt,
    input  logic [`EXEC_DATA_W-1:0]      fwd_rs_data,
    input  logic [`EXEC_DATA_W-1:0]      fwd_rt_data,
    input  logic [`EXEC_DATA_W-1:0]      hi,
    input  logic [`EXEC_DATA_W-1:0]      lo,
    input  logic                         llbit,
    output logic                         valid_out,
    output logic [`EXEC_DATA_W-1:0]      alu_out,
    output logic                         overflow,
    output logic                         flag,
    output logic [`EXEC_DATA_W-1:0]      dest_reg_data,
    output logic [`EXEC_REG_W-1:0]       dest_reg,
    output logic [`EXEC_DATA_W-1:0]      store_data
);

    logic [isa_pkg::INSTR_W-1:0] instr_q;
    isa_pkg::alu_funct_e         alu_funct_q;
    exec_ctrl_pkg::alu_src_a_e   alu_src_a_q;
    exec_ctrl_pkg::alu_src_b_e   alu_src_b_q;
    exec_ctrl_pkg::reg_src_e     reg_src_q;
    exec_ctrl_pkg::flag_sel_e    flag_sel_q;
    exec_ctrl_pkg::dest_sel_e    dest_sel_q;
    logic [`EXEC_DATA_W-1:0]     pcadd4_q, rs_q, rt_q, cp0_q;
    logic [`EXEC_DATA_W-1:0]     alu_a, alu_b, rs_data, rt_data;
    logic [`EXEC_SA_W-1:0]       alu_sa;
    logic [`EXEC_REG_W-1:0]      rd, rt_addr;
    logic                        eq, lt, ltu;

    exec_stage_reg u_stage_reg (
        .clk, .rst_n, .stall, .nullify, .valid_in, .instr_in, .alu_funct_in,
        .alu_src_a_in, .alu_src_b_in, .reg_src_in, .flag_sel_in, .dest_sel_in,
        .pcadd4_in, .rs_in, .rt_in, .cp0_in,
        .valid_q(valid_out), .instr_q, .alu_funct_q, .alu_src_a_q, .alu_src_b_q,
        .reg_src_q, .flag_sel_q, .dest_sel_q, .pcadd4_q, .rs_q, .rt_q, .cp0_q);

    exec_operand_select u_operand_select (
        .clk, .rst_n, .valid(valid_out), .instr(instr_q),
        .alu_src_a(alu_src_a_q), .alu_src_b(alu_src_b_q), .rs_q, .rt_q,
        .forward_rs, .forward_rt, .fwd_rs_data, .fwd_rt_data,
        .alu_a, .alu_b, .alu_sa, .rs_data, .rt_data, .rd, .rt_addr);

    alu #(.W(`EXEC_DATA_W), .SA_W(`EXEC_SA_W)) u_alu (
        .a(alu_a), .b(alu_b), .sa(alu_sa), .funct(alu_funct_q),
        .y(alu_out), .eq, .lt, .ltu, .overflow);

    exec_result_select u_result_select (
        .flag_sel(flag_sel_q), .reg_src(reg_src_q), .dest_sel(dest_sel_q),
        .alu_y(alu_out), .eq, .lt, .ltu, .pcadd4(pcadd4_q), .rs_data,
        .hi, .lo, .cp0(cp0_q), .llbit, .rd, .rt_addr,
        .flag, .dest_reg_data, .dest_reg);

    assign store_data = rt_data; // sw takes the forwarded rt.

endmodule

/* exec_checker.sv */
`timescale 1ns/10ps
`include "exec_defines.svh"

module exec_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_in,
    input  logic                    stall,
    input  logic                    nullify,
    input  logic [`EXEC_DATA_W-1:0] exp_alu,
    input  logic                    exp_ovf,
    input  logic                    exp_flag,
    input  logic [`EXEC_DATA_W-1:0] exp_data,
    input  logic [`EXEC_REG_W-1:0]  exp_dest,
    input  logic [`EXEC_DATA_W-1:0] exp_store,
    input  logic                    valid_out,
    input  logic [`EXEC_DATA_W-1:0] alu_out,
    input  logic                    overflow,
    input  logic                    flag,
    input  logic [`EXEC_DATA_W-1:0] dest_reg_data,
    input  logic [`EXEC_REG_W-1:0]  dest_reg,
    input  logic [`EXEC_DATA_W-1:0] store_data,
    output int                      errors
);

    logic                    q_valid;
    logic [`EXEC_DATA_W-1:0] q_alu;
    logic                    q_ovf;
    logic                    q_flag;
    logic [`EXEC_DATA_W-1:0] q_data;
    logic [`EXEC_REG_W-1:0]  q_dest;
    logic [`EXEC_DATA_W-1:0] q_store;

    initial errors = 0;

    // one-entry copy of the stage register.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else if (nullify) begin
            q_valid <= 1'b0;
        end else if (!stall) begin
            q_valid <= valid_in;
            q_alu   <= exp_alu;
            q_ovf   <= exp_ovf;
            q_flag  <= exp_flag;
            q_data  <= exp_data;
            q_dest  <= exp_dest;
            q_store <= exp_store;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, want, $time);
        end
    endtask

    // outputs are settled halfway through the cycle.
    always @(negedge clk) begin
        if (rst_n) begin
            compare_value("valid_out", {31'b0, valid_out}, {31'b0, q_valid});
            if (q_valid) begin
                compare_value("alu_out", alu_out, q_alu);
                compare_value("overflow", {31'b0, overflow}, {31'b0, q_ovf});
                compare_value("flag", {31'b0, flag}, {31'b0, q_flag});
                compare_value("dest_reg_data", dest_reg_data, q_data);
                compare_value("dest_reg", {27'b0, dest_reg}, {27'b0, q_dest});
                compare_value("store_data", store_data, q_store);
            end
        end
    end

endmodule

/* tb_stage_execute.sv */
`timescale 1ns/10ps
`include "exec_defines.svh"

module tb_stage_execute;

    typedef struct {
        logic [31:0] instr;
        isa_pkg::alu_funct_e funct;
        exec_ctrl_pkg::alu_src_a_e src_a;
        exec_ctrl_pkg::alu_src_b_e src_b;
        exec_ctrl_pkg::reg_src_e reg_src;
        exec_ctrl_pkg::flag_sel_e flag_sel;
        exec_ctrl_pkg::dest_sel_e dest_sel;
        logic [31:0] rs, rt, pcadd4, cp0, hi, lo, fwd_rs_data, fwd_rt_data;
        logic llbit, fwd_rs, fwd_rt, stall, nullify;
        logic [31:0] e_alu, e_data, e_store;
        logic e_ovf, e_flag;
        logic [4:0] e_dest;
    } row_t;

    // rd 8, rt 10, sa 4, imm 4100.
    localparam logic [31:0] IA = 32'h012A4100;
    // rd 16, rt 10, sa 0, imm 8004.
    localparam logic [31:0] IB = 32'h012A8004;

    logic clk, rst_n, valid_in, stall, nullify, forward_rs, forward_rt, llbit;
    logic [31:0] instr_in, pcadd4_in, rs_in, rt_in, cp0_in;
    logic [31:0] fwd_rs_data, fwd_rt_data, hi, lo;
    isa_pkg::alu_funct_e alu_funct_in;
    exec_ctrl_pkg::alu_src_a_e alu_src_a_in;
    exec_ctrl_pkg::alu_src_b_e alu_src_b_in;
    exec_ctrl_pkg::reg_src_e reg_src_in;
    exec_ctrl_pkg::flag_sel_e flag_sel_in;
    exec_ctrl_pkg::dest_sel_e dest_sel_in;
    logic valid_out, overflow, flag;
    logic [31:0] alu_out, dest_reg_data, store_data;
    logic [4:0] dest_reg;
    logic [31:0] exp_alu, exp_data, exp_store;
    logic exp_ovf, exp_flag;
    logic [4:0] exp_dest;
    int check_errors, timeouts;
    int seed = 11721;
    row_t r;
    row_t rows[$];

    stage_execute dut (.*);

    exec_checker u_checker (
        .clk, .rst_n, .valid_in, .stall, .nullify, .exp_alu, .exp_ovf, .exp_flag,
        .exp_data, .exp_dest, .exp_store, .valid_out, .alu_out, .overflow, .flag,
        .dest_reg_data, .dest_reg, .store_data, .errors(check_errors));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fill(input logic [3:0] f, input logic [31:0] instr, rs, rt, e_alu,
                        input logic e_ovf, e_flag, input logic [4:0] e_dest);
        r = '{instr: instr, funct: isa_pkg::alu_funct_e'(f), rs: rs, rt: rt,
              src_a: exec_ctrl_pkg::SRC_A_RS, src_b: exec_ctrl_pkg::SRC_B_RT,
              reg_src: exec_ctrl_pkg::REG_SRC_ALU, flag_sel: exec_ctrl_pkg::FLAG_EQ,
              dest_sel: exec_ctrl_pkg::DEST_RD,
              pcadd4: 32'h00001004, cp0: 32'hC0C00001, hi: 32'h11112222,
              lo: 32'h33334444, fwd_rs_data: 32'hDEADBEEF, fwd_rt_data: 32'hFEEDF00D,
              llbit: 1'b1, e_alu: e_alu, e_data: e_alu, e_store: rt, e_ovf: e_ovf,
              e_flag: e_flag, e_dest: e_dest, default: '0};
    endtask

    // reference model for the random rows.
    function automatic void expect_row(inout row_t t);
        logic [31:0] a, b, rsd, rtd;
        logic [32:0] wide;
        logic [4:0] amt;
        rsd = t.fwd_rs ? t.fwd_rs_data : t.rs;
        rtd = t.fwd_rt ? t.fwd_rt_data : t.rt;
        a = (t.src_a == exec_ctrl_pkg::SRC_A_ZERO) ? 32'h0 : rsd;
        case (t.src_b)
            exec_ctrl_pkg::SRC_B_IMM_SIGN: b = 32'($signed(t.instr[15:0]));
            exec_ctrl_pkg::SRC_B_IMM_ZERO: b = {16'h0, t.instr[15:0]};
            default: b = rtd;
        endcase
        amt = (t.funct >= isa_pkg::ALU_SLLV) ? a[4:0] : t.instr[10:6];
        t.e_ovf = 1'b0;
        case (t.funct)
            isa_pkg::ALU_ADD, isa_pkg::ALU_ADDU: begin
                wide = {a[31], a} + {b[31], b};
                t.e_alu = wide[31:0];
                t.e_ovf = (t.funct == isa_pkg::ALU_ADD) && (wide[32] != wide[31]);
            end
            isa_pkg::ALU_SUB, isa_pkg::ALU_SUBU: begin
                wide = {a[31], a} - {b[31], b};
                t.e_alu = wide[31:0];
                t.e_ovf = (t.funct == isa_pkg::ALU_SUB) && (wide[32] != wide[31]);
            end
            isa_pkg::ALU_AND: t.e_alu = a & b;
            isa_pkg::ALU_OR:  t.e_alu = a | b;
            isa_pkg::ALU_XOR: t.e_alu = a ^ b;
            isa_pkg::ALU_NOR: t.e_alu = ~(a | b);
            isa_pkg::ALU_SLL, isa_pkg::ALU_SLLV: t.e_alu = b << amt;
            isa_pkg::ALU_SRL, isa_pkg::ALU_SRLV: t.e_alu = b >> amt;
            isa_pkg::ALU_SRA, isa_pkg::ALU_SRAV: t.e_alu = 32'($signed(b) >>> amt);
            default: t.e_alu = b * 32'h10000;
        endcase
        case (t.flag_sel)
            exec_ctrl_pkg::FLAG_EQ: t.e_flag = (a == b);
            exec_ctrl_pkg::FLAG_NE: t.e_flag = (a != b);
            exec_ctrl_pkg::FLAG_LT: t.e_flag = ($signed(a) < $signed(b));
            default: t.e_flag = (a < b);
        endcase
        case (t.reg_src)
            exec_ctrl_pkg::REG_SRC_ALU: t.e_data = t.e_alu;
            exec_ctrl_pkg::REG_SRC_PCADD4: t.e_data = t.pcadd4;
            exec_ctrl_pkg::REG_SRC_RS: t.e_data = rsd;
            exec_ctrl_pkg::REG_SRC_HI: t.e_data = t.hi;
            exec_ctrl_pkg::REG_SRC_LO: t.e_data = t.lo;
            exec_ctrl_pkg::REG_SRC_CP0: t.e_data = t.cp0;
            exec_ctrl_pkg::REG_SRC_FLAG: t.e_data = {31'h0, t.e_flag};
            default: t.e_data = {31'h0, t.llbit};
        endcase
        if (t.dest_sel == exec_ctrl_pkg::DEST_RT) t.e_dest = t.instr[20:16];
        else if (t.dest_sel == exec_ctrl_pkg::DEST_RA) t.e_dest = 5'd31;
        else t.e_dest = t.instr[15:11];
        t.e_store = rtd;
    endfunction

    function automatic row_t random_row();
        row_t t;
        t = '{instr: $random(seed), rs: $random(seed), rt: $random(seed),
              pcadd4: $random(seed), cp0: $random(seed), hi: $random(seed),
              lo: $random(seed), fwd_rs_data: $random(seed), fwd_rt_data: $random(seed),
              funct: isa_pkg::alu_funct_e'($unsigned($random(seed)) % 15),
              src_a: exec_ctrl_pkg::alu_src_a_e'($random(seed) & 1),
              src_b: exec_ctrl_pkg::alu_src_b_e'($unsigned($random(seed)) % 3),
              reg_src: exec_ctrl_pkg::reg_src_e'($random(seed) & 7),
              flag_sel: exec_ctrl_pkg::flag_sel_e'($random(seed) & 3),
              dest_sel: exec_ctrl_pkg::dest_sel_e'($unsigned($random(seed)) % 3),
              default: '0};
        t.llbit = $random(seed) & 1;
        t.fwd_rs = $random(seed) & 1;
        t.fwd_rt = $random(seed) & 1;
        t.stall = ($random(seed) & 7) == 0;
        t.nullify = ($random(seed) & 7) == 1;
        return t;
    endfunction

    task automatic apply_row(input row_t t, input int idx);
        int waited;
        @(posedge clk);
        valid_in <= 1'b1;
        instr_in <= t.instr;
        alu_funct_in <= t.funct;
        alu_src_a_in <= t.src_a;
        alu_src_b_in <= t.src_b;
        reg_src_in <= t.reg_src;
        flag_sel_in <= t.flag_sel;
        dest_sel_in <= t.dest_sel;
        pcadd4_in <= t.pcadd4;
        rs_in <= t.rs;
        rt_in <= t.rt;
        cp0_in <= t.cp0;
        forward_rs <= t.fwd_rs;
        forward_rt <= t.fwd_rt;
        fwd_rs_data <= t.fwd_rs_data;
        fwd_rt_data <= t.fwd_rt_data;
        hi <= t.hi;
        lo <= t.lo;
        llbit <= t.llbit;
        stall <= 1'b0;
        nullify <= 1'b0;
        exp_alu <= t.e_alu;
        exp_ovf <= t.e_ovf;
        exp_flag <= t.e_flag;
        exp_data <= t.e_data;
        exp_dest <= t.e_dest;
        exp_store <= t.e_store;
        @(posedge clk);
        valid_in <= t.stall | t.nullify;
        rs_in <= ~t.rs; // a held stage must ignore this.
        stall <= t.stall;
        nullify <= t.nullify;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (valid_out !== 1'b1 && waited < 8);
        if (valid_out !== 1'b1) begin
            timeouts++;
            $display("row %0d: valid_out did not rise within 8 cycles", idx);
        end
        if (t.stall || t.nullify) begin
            @(posedge clk);
            stall <= 1'b0;
            nullify <= 1'b0;
            valid_in <= 1'b0;
        end
    endtask

    initial begin
        timeouts = 0;
        rst_n = 1'b0;
        {valid_in, stall, nullify, forward_rs, forward_rt, llbit} = '0;
        {instr_in, pcadd4_in, rs_in, rt_in, cp0_in, fwd_rs_data, fwd_rt_data} = '0;
        {hi, lo, exp_alu, exp_data, exp_store, exp_ovf, exp_flag, exp_dest} = '0;
        alu_funct_in = isa_pkg::ALU_ADD;
        alu_src_a_in = exec_ctrl_pkg::SRC_A_RS;
        alu_src_b_in = exec_ctrl_pkg::SRC_B_RT;
        reg_src_in = exec_ctrl_pkg::REG_SRC_ALU;
        flag_sel_in = exec_ctrl_pkg::FLAG_EQ;
        dest_sel_in = exec_ctrl_pkg::DEST_RD;

        fill(0, IA, 32'h7FFFFFFF, 32'h1, 32'h80000000, 1, 0, 8);
        rows.push_back(r);
        fill(1, IA, 32'h7FFFFFFF, 32'h1, 32'h80000000, 0, 0, 8);
        rows.push_back(r);
        fill(2, IA, 32'h80000000, 32'h1, 32'h7FFFFFFF, 1, 0, 8);
        rows.push_back(r);
        fill(3, IA, 32'h80000000, 32'h1, 32'h7FFFFFFF, 0, 0, 8);
        rows.push_back(r);
        fill(4, IA, 32'hF0F0FF00, 32'h0FF00FF0, 32'h00F00F00, 0, 0, 8);
        r.stall = 1'b1;
        rows.push_back(r);
        fill(5, IA, 32'hF0F0FF00, 32'h0FF00FF0, 32'hFFF0FFF0, 0, 0, 8);
        r.nullify = 1'b1;
        rows.push_back(r);
        fill(6, IA, 32'hF0F0FF00, 32'h0FF00FF0, 32'hFF00F0F0, 0, 0, 8);
        r.stall = 1'b1;
        r.nullify = 1'b1;
        rows.push_back(r);
        fill(7, IA, 32'hF0F0FF00, 32'h0FF00FF0, 32'h000F000F, 0, 0, 8);
        rows.push_back(r);
        fill(8, IA, 32'h3, 32'h80000001, 32'h00000010, 0, 0, 8);
        rows.push_back(r);
        fill(9, IA, 32'h3, 32'h80000001, 32'h08000000, 0, 0, 8);
        rows.push_back(r);
        fill(10, IA, 32'h3, 32'h80000001, 32'hF8000000, 0, 0, 8);
        rows.push_back(r);
        fill(11, IA, 32'h3, 32'h80000001, 32'h00000008, 0, 0, 8);
        rows.push_back(r);
        fill(12, IA, 32'h3, 32'h80000001, 32'h10000000, 0, 0, 8);
        rows.push_back(r);
        fill(13, IA, 32'h3, 32'h80000001, 32'hF0000000, 0, 0, 8);
        rows.push_back(r);
        fill(3, IA, 32'h7, 32'h7, 32'h0, 0, 1, 8);
        rows.push_back(r);
        fill(14, IA, 32'h5, 32'h9, 32'h41000000, 0, 0, 8);
        r.src_a = exec_ctrl_pkg::SRC_A_ZERO;
        r.src_b = exec_ctrl_pkg::SRC_B_IMM_ZERO;
        rows.push_back(r);
        fill(1, IB, 32'h10, 32'h0, 32'hFFFF8014, 0, 0, 10);
        r.src_b = exec_ctrl_pkg::SRC_B_IMM_SIGN;
        r.dest_sel = exec_ctrl_pkg::DEST_RT;
        rows.push_back(r);
        fill(1, IB, 32'h10, 32'h0, 32'h00008014, 0, 0, 16);
        r.src_b = exec_ctrl_pkg::SRC_B_IMM_ZERO;
        r.reg_src = exec_ctrl_pkg::REG_SRC_PCADD4;
        r.e_data = 32'h00001004;
        rows.push_back(r);
        fill(1, IA, 32'h1, 32'h2, 32'h300, 0, 0, 31);
        r.fwd_rs = 1'b1;
        r.fwd_rt = 1'b1;
        r.fwd_rs_data = 32'h100;
        r.fwd_rt_data = 32'h200;
        r.reg_src = exec_ctrl_pkg::REG_SRC_RS;
        r.dest_sel = exec_ctrl_pkg::DEST_RA;
        r.e_data = 32'h100;
        r.e_store = 32'h200;
        rows.push_back(r);
        fill(0, IA, 32'h5, 32'h6, 32'h0000000B, 0, 1, 8);
        r.reg_src = exec_ctrl_pkg::REG_SRC_HI;
        r.flag_sel = exec_ctrl_pkg::FLAG_NE;
        r.e_data = 32'h11112222;
        rows.push_back(r);
        fill(0, IA, 32'hFFFFFFFF, 32'h1, 32'h0, 0, 1, 8);
        r.reg_src = exec_ctrl_pkg::REG_SRC_LO;
        r.flag_sel = exec_ctrl_pkg::FLAG_LT;
        r.e_data = 32'h33334444;
        rows.push_back(r);
        fill(0, IA, 32'hFFFFFFFF, 32'h1, 32'h0, 0, 0, 8);
        r.reg_src = exec_ctrl_pkg::REG_SRC_CP0;
        r.flag_sel = exec_ctrl_pkg::FLAG_LTU;
        r.e_data = 32'hC0C00001;
        rows.push_back(r);
        fill(0, IA, 32'hFFFFFFFF, 32'h1, 32'h0, 0, 1, 8);
        r.reg_src = exec_ctrl_pkg::REG_SRC_FLAG;
        r.flag_sel = exec_ctrl_pkg::FLAG_LT;
        r.e_data = 32'h1;
        rows.push_back(r);
        fill(0, IA, 32'h5, 32'h6, 32'h0000000B, 0, 0, 8);
        r.reg_src = exec_ctrl_pkg::REG_SRC_LLBIT;
        r.e_data = 32'h1;
        rows.push_back(r);
        for (int i = 0; i < 40; i++) begin
            r = random_row();
            expect_row(r);
            rows.push_back(r);
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk); // stage stays empty until the first load.
        foreach (rows[i]) begin
            apply_row(rows[i], i);
        end
        @(posedge clk);
        valid_in <= 1'b0;
        repeat (3) @(posedge clk);

        $display("check errors %0d, timeouts %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
isa_pkg.sv
exec_ctrl_pkg.sv
exec_stage_reg.sv
exec_operand_select.sv
alu.sv
exec_result_select.sv
stage_execute.sv
exec_checker.sv
tb_stage_execute.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the execute stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_stage_execute -f build.f -o sim_exec

# the simulation result is judged from the log below.
./obj_dir/sim_exec > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
